/* project.f */
+incdir+.
md_pair_pkg.sv
md_force_pkg.sv
pair_fifo.sv
cutoff_regs.sv
pair_filter.sv
force_pipeline.sv
md_eval_top.sv
md_eval_checker.sv
md_eval_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the md_eval testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module md_eval_tb -o md_eval_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/md_eval_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
	exit 1
fi
exit 0

/* md_eval_tb.sv */
/*
  Testbench for md_eval_top with random pairs and an integer reference model.
  The seed is fixed. A cycle limit set from the pair count ends a hung run.
*/
`timescale 1ns/100ps
`include "md_cfg.svh"

module md_eval_tb;

	localparam int SEED = 73299;
	localparam int N_FORCE = 60;
	localparam int N_FILTER = 60;
	localparam int N_CUTOFF = 60;
	localparam int N_BACK = 150;
	localparam int N_TOTAL = N_FORCE + N_FILTER + N_CUTOFF + N_BACK;
	localparam int CYCLE_LIMIT = N_TOTAL * 40 + 2000;
	localparam logic [`MD_R2_W-1:0] SMALL_CUTOFF = 22'h030000;

	// DUT ports
	logic                     clk = 1'b0;
	logic                     rst;
	logic                     ivalid;
	md_pair_pkg::pair_in_t    in_pair;
	logic                     oready;
	logic                     iready;
	logic                     ovalid;
	md_force_pkg::force_out_t out_force;
	logic                     cfg_we;
	logic [`MD_R2_W-1:0]      cfg_cutoff;

	// Model and bookkeeping
	md_force_pkg::force_out_t exp_q [$];
	md_force_pkg::force_out_t exp_word;
	int    model_cutoff;
	string test_name;
	int    errors;
	int    start_errors;
	int    kept_count;
	int    drop_count;
	int    narrowed_count;
	int    out_count;
	int    total_checked;
	int    cycles;
	bit    saw_oready_low;
	// Downstream mode 0 holds iready high and mode 1 randomizes it
	int    ready_mode;
	int    hold_low;

	md_eval_top UUT
	(
		.clk(clk),
		.rst(rst),
		.ivalid(ivalid),
		.in_pair(in_pair),
		.oready(oready),
		.iready(iready),
		.ovalid(ovalid),
		.out_force(out_force),
		.cfg_we(cfg_we),
		.cfg_cutoff(cfg_cutoff)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// Run limit
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles in test %s", cycles, test_name);
			$display("TB FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	// Keep decision returned and expected result word in res
	function automatic bit model_pair(input md_pair_pkg::pair_in_t p, input int cut,
		output md_force_pkg::force_out_t res);
		int dx;
		int dy;
		int dz;
		int r2;
		int coef;
		dx = int'(p.nbr_pos.x) - int'(p.ref_pos.x);
		dy = int'(p.nbr_pos.y) - int'(p.ref_pos.y);
		dz = int'(p.nbr_pos.z) - int'(p.ref_pos.z);
		r2 = dx * dx + dy * dy + dz * dz;
		// Bin from the upper r2 bits and coefficient of 255 minus bin
		coef = 255 - (r2 >> (`MD_R2_W - `MD_BIN_W));
		res.ids = p.ids;
		res.fx = `MD_FORCE_W'(dx * coef);
		res.fy = `MD_FORCE_W'(dy * coef);
		res.fz = `MD_FORCE_W'(dz * coef);
		return r2 < cut;
	endfunction

	// Small ref_span pulls the reference toward the origin and drops more pairs
	function automatic md_pair_pkg::pair_in_t random_pair(input int ref_span);
		md_pair_pkg::pair_in_t p;
		p.ids.ref_id = `MD_ID_W'($urandom);
		p.ids.nbr_id = `MD_ID_W'($urandom);
		p.ref_pos.x = `MD_COORD_W'($urandom % ref_span);
		p.ref_pos.y = `MD_COORD_W'($urandom % ref_span);
		p.ref_pos.z = `MD_COORD_W'($urandom % ref_span);
		p.nbr_pos.x = `MD_COORD_W'($urandom);
		p.nbr_pos.y = `MD_COORD_W'($urandom);
		p.nbr_pos.z = `MD_COORD_W'($urandom);
		return p;
	endfunction

	////////////////////////////////////////////////////////////
	// Drivers and monitor
	////////////////////////////////////////////////////////////
	// Entered and left on a falling edge with the pair held until oready
	task automatic send_pair(input md_pair_pkg::pair_in_t p);
		md_force_pkg::force_out_t res;
		ivalid = 1'b1;
		in_pair = p;
		while (!oready)
			@(negedge clk);
		// Accepted at the coming rising edge
		if (model_pair(p, model_cutoff, res))
		begin
			exp_q.push_back(res);
			kept_count++;
		end
		else
		begin
			drop_count++;
			// Dropped now but kept under the reset cutoff
			if (model_pair(p, int'(`MD_CUTOFF_RESET), res))
				narrowed_count++;
		end
		@(negedge clk);
		ivalid = 1'b0;
	endtask

	task automatic set_cutoff(input logic [`MD_R2_W-1:0] value);
		cfg_cutoff = value;
		cfg_we = 1'b1;
		@(negedge clk);
		cfg_we = 1'b0;
		model_cutoff = int'(value);
		// Input idle while the new value settles
		repeat (2) @(negedge clk);
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
			@(negedge clk);
		// Idle cycles catch late or duplicated results
		repeat (30) @(negedge clk);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		start_errors = errors;
		kept_count = 0;
		drop_count = 0;
		narrowed_count = 0;
		out_count = 0;
	endtask

	task automatic finish_test();
		assert (out_count == kept_count)
		else
		begin
			$display("MISMATCH test %s: result count expected %0d actual %0d",
				test_name, kept_count, out_count);
			errors++;
		end
		$display("Test %s %s: %0d kept, %0d dropped, %0d errors", test_name,
			(errors == start_errors) ? "ok" : "failed", kept_count, drop_count,
			errors - start_errors);
	endtask

	// Random downstream ready with occasional long stalls
	always @(negedge clk)
	begin
		if (hold_low > 0)
		begin
			iready = 1'b0;
			hold_low = hold_low - 1;
		end
		else if (ready_mode == 1)
		begin
			iready = ($urandom % 2) == 0;
			if ($urandom % 40 == 0)
				hold_low = 20 + $urandom % 20;
		end
		else
			iready = 1'b1;
	end

	// Outputs only move on the rising edge so they are stable here
	always @(negedge clk)
	begin
		if (!rst && !oready)
			saw_oready_low = 1'b1;
		if (!rst && ovalid)
		begin
			out_count++;
			if (exp_q.size() == 0)
			begin
				$display("Test %s: result with ids %h arrived with no pair pending",
					test_name, out_force.ids);
				errors++;
			end
			else
			begin
				exp_word = exp_q.pop_front();
				total_checked++;
				assert (out_force == exp_word)
				else
				begin
					$display("MISMATCH test %s: expected %h actual %h",
						test_name, exp_word, out_force);
					errors++;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		void'($urandom(SEED));
		rst = 1'b1;
		ivalid = 1'b0;
		in_pair = '0;
		iready = 1'b1;
		cfg_we = 1'b0;
		cfg_cutoff = '0;
		ready_mode = 0;
		hold_low = 0;
		errors = 0;
		total_checked = 0;
		cycles = 0;
		saw_oready_low = 1'b0;
		model_cutoff = int'(`MD_CUTOFF_RESET);
		test_name = "reset";
		repeat (3) @(negedge clk);
		rst = 1'b0;

		// Idle ports right after reset
		start_test("reset_state");
		repeat (8)
		begin
			@(negedge clk);
			assert (oready === 1'b1 && ovalid === 1'b0)
			else
			begin
				$display("Test %s: after reset oready is %b and ovalid is %b, expected 1 and 0",
					test_name, oready, ovalid);
				errors++;
			end
		end
		finish_test();

		start_test("force_values");
		repeat (N_FORCE) send_pair(random_pair(1024));
		drain();
		finish_test();

		start_test("filtering");
		repeat (N_FILTER) send_pair(random_pair(256));
		drain();
		assert (drop_count > 0 && kept_count > 0)
		else
		begin
			$display("Test %s: stimulus did not give both kept and dropped pairs", test_name);
			errors++;
		end
		finish_test();

		start_test("cutoff_write");
		set_cutoff(SMALL_CUTOFF);
		repeat (N_CUTOFF) send_pair(random_pair(1024));
		drain();
		assert (narrowed_count > 0)
		else
		begin
			$display("Test %s: no pair fell between the new and the reset cutoff", test_name);
			errors++;
		end
		finish_test();

		// Long stall first and random ready after it
		start_test("back_pressure");
		set_cutoff(`MD_CUTOFF_RESET);
		saw_oready_low = 1'b0;
		hold_low = 150;
		ready_mode = 1;
		repeat (N_BACK) send_pair(random_pair(1024));
		ready_mode = 0;
		hold_low = 0;
		drain();
		assert (saw_oready_low)
		else
		begin
			$display("Test %s: oready never fell while the output was stalled", test_name);
			errors++;
		end
		finish_test();

		$display("Summary: 5 tests, %0d results checked, %0d errors", total_checked, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* md_eval_checker.sv */
/*
  Port protocol assertions for md_eval_top, attached by bind.
  The input FIFO count is watched through the bound instance.
*/
`timescale 1ns/100ps
`include "md_cfg.svh"

module md_eval_checker
(
	input logic                                  clk,
	input logic                                  rst,
	input logic                                  ivalid,
	input logic                                  oready,
	input logic [$clog2(`MD_IN_DEPTH + 1)-1:0]   in_used,
	input logic                                  iready,
	input logic                                  ovalid,
	input logic                                  cfg_we
);

	// Output strobe quiet in the first cycle out of reset
	ovalid_after_reset: assert property (@(posedge clk) $past(rst) |-> !ovalid)
		else $error("ovalid high in the cycle after reset");

	// Result only follows a downstream read
	ovalid_follows_iready: assert property (@(posedge clk) disable iff (rst)
		ovalid |-> $past(iready))
		else $error("ovalid high without iready in the previous cycle");

	// Input FIFO count never grows while oready is low
	no_write_without_ready: assert property (@(posedge clk) disable iff (rst)
		(ivalid && !oready) |=> (in_used <= $past(in_used)))
		else $error("pair accepted while oready was low");

	no_cfg_in_reset: assert property (@(posedge clk) rst |-> !cfg_we)
		else $error("cfg_we high during reset");

endmodule

// Attached to every top-level instance
bind md_eval_top md_eval_checker u_checker
(
	.clk(clk),
	.rst(rst),
	.ivalid(ivalid),
	.oready(oready),
	.in_used(in_used),
	.iready(iready),
	.ovalid(ovalid),
	.cfg_we(cfg_we)
);

/* md_eval_top.sv */
/*
  Pair filter and force evaluator top level.
  Upstream holds in_pair while oready is low. ovalid is a one-cycle strobe
  per result, one cycle after the output read. Pair order is preserved.
*/
`timescale 1ns/100ps
`include "md_cfg.svh"

module md_eval_top
(
	input  logic                     clk,
	input  logic                     rst,
	// Upstream side
	input  logic                     ivalid,
	input  md_pair_pkg::pair_in_t    in_pair,
	output logic                     oready,
	// Downstream side
	input  logic                     iready,
	output logic                     ovalid,
	output md_force_pkg::force_out_t out_force,
	// Cutoff configuration
	input  logic                     cfg_we,
	input  logic [`MD_R2_W-1:0]      cfg_cutoff
);

	localparam int IN_CNT_W = $clog2(`MD_IN_DEPTH + 1);
	localparam int OUT_CNT_W = $clog2(`MD_OUT_DEPTH + 1);
	// Early ready, two entries short of full
	localparam logic [IN_CNT_W-1:0] IN_READY_LEVEL = IN_CNT_W'(`MD_IN_DEPTH - 2);
	// Issue only with room for every pair in flight
	localparam logic [OUT_CNT_W-1:0] ISSUE_LEVEL =
		OUT_CNT_W'(`MD_OUT_DEPTH - `MD_FORCE_LATENCY - 2);

	// Input FIFO side
	logic [IN_CNT_W-1:0]      in_used;
	logic                     in_empty;
	logic                     in_wr;
	logic                     in_rd;
	logic                     in_valid;
	md_pair_pkg::pair_in_t    fifo_pair;
	// Filter and pipeline
	logic [`MD_R2_W-1:0]      cutoff;
	md_force_pkg::kept_pair_t kept;
	logic                     kept_available;
	logic                     back_pressure;
	logic                     pop;
	logic                     issue_valid;
	logic                     force_valid;
	md_force_pkg::force_out_t force_res;
	// Output FIFO side
	logic [OUT_CNT_W-1:0]     out_used;
	logic                     out_empty;
	logic                     out_rd;

	////////////////////////////////////////////////////////////
	// Flow control decisions
	////////////////////////////////////////////////////////////
	assign oready = (in_used < IN_READY_LEVEL);
	assign in_wr = ivalid && oready;
	assign in_rd = ~in_empty && ~back_pressure;
	assign pop = kept_available && (out_used <= ISSUE_LEVEL);
	assign out_rd = ~out_empty && iready;

	// FIFO read data lands one cycle after each read
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			in_valid <= 1'b0;
			issue_valid <= 1'b0;
			ovalid <= 1'b0;
		end
		else
		begin
			in_valid <= in_rd;
			issue_valid <= pop;
			ovalid <= out_rd;
		end
	end

	////////////////////////////////////////////////////////////
	// Instances
	////////////////////////////////////////////////////////////
	pair_fifo #(.WIDTH($bits(md_pair_pkg::pair_in_t)), .DEPTH(`MD_IN_DEPTH)) u_in_fifo
	(
		.clk(clk),
		.rst(rst),
		.wr_en(in_wr),
		.wr_data(in_pair),
		.rd_en(in_rd),
		.rd_data(fifo_pair),
		.empty(in_empty),
		.used(in_used)
	);

	cutoff_regs u_cutoff
	(
		.clk(clk),
		.rst(rst),
		.cfg_we(cfg_we),
		.cfg_cutoff(cfg_cutoff),
		.cutoff(cutoff)
	);

	pair_filter u_filter
	(
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_pair(fifo_pair),
		.cutoff(cutoff),
		.pop(pop),
		.kept(kept),
		.kept_available(kept_available),
		.back_pressure(back_pressure)
	);

	force_pipeline u_force
	(
		.clk(clk),
		.rst(rst),
		.issue_valid(issue_valid),
		.kept(kept),
		.force_valid(force_valid),
		.force_out(force_res)
	);

	// Output FIFO written straight from the pipeline
	pair_fifo #(.WIDTH($bits(md_force_pkg::force_out_t)), .DEPTH(`MD_OUT_DEPTH)) u_out_fifo
	(
		.clk(clk),
		.rst(rst),
		.wr_en(force_valid),
		.wr_data(force_res),
		.rd_en(out_rd),
		.rd_data(out_force),
		.empty(out_empty),
		.used(out_used)
	);

endmodule

/* force_pipeline.sv */
/*
  Three-stage force evaluation with no stalls.
  Coefficient per bin is (2**MD_BIN_W - 1) - bin. IDs ride with the data.
*/
`timescale 1ns/100ps
`include "md_cfg.svh"

module force_pipeline
(
	input  logic                     clk,
	input  logic                     rst,
	// One cycle after the filter buffer pop
	input  logic                     issue_valid,
	input  md_force_pkg::kept_pair_t kept,
	// To the output FIFO write port
	output logic                     force_valid,
	output md_force_pkg::force_out_t force_out
);

	localparam int LAT = `MD_FORCE_LATENCY;
	localparam int FORCE_W = `MD_FORCE_W;
	localparam int BIN_NUM = 1 << `MD_BIN_W;

	// Coefficient table, one entry per bin
	logic [`MD_COEF_W-1:0] coef_rom [0:BIN_NUM-1];

	// Valid bits shifted along the stages
	logic [LAT-1:0] vld;

	// Stage registers
	md_force_pkg::kept_pair_t   s1_pair;
	logic [`MD_COEF_W-1:0]      s1_coef;
	logic signed [FORCE_W-1:0]  coef_ext;
	md_pair_pkg::pair_ids_t     s2_ids;
	logic signed [FORCE_W-1:0]  s2_fx;
	logic signed [FORCE_W-1:0]  s2_fy;
	logic signed [FORCE_W-1:0]  s2_fz;

	////////////////////////////////////////////////////////////
	// Coefficient table
	////////////////////////////////////////////////////////////
	// Falls linearly with the bin
	always_comb
	begin
		for (int b = 0; b < BIN_NUM; b++)
			coef_rom[b] = `MD_COEF_W'(BIN_NUM - 1 - b);
	end

	// Coefficient is unsigned, widened before the signed multiply
	assign coef_ext = $signed(FORCE_W'(s1_coef));

	////////////////////////////////////////////////////////////
	// Pipeline stages
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		// Stage 1 table read by the bin view of r2
		s1_pair <= kept;
		s1_coef <= coef_rom[kept.r2.fields.bin];
		// Stage 2 products, differences sign extended first
		s2_ids <= s1_pair.ids;
		s2_fx <= FORCE_W'(s1_pair.diff.dx) * coef_ext;
		s2_fy <= FORCE_W'(s1_pair.diff.dy) * coef_ext;
		s2_fz <= FORCE_W'(s1_pair.diff.dz) * coef_ext;
		// Stage 3 result word
		force_out.ids <= s2_ids;
		force_out.fx <= s2_fx;
		force_out.fy <= s2_fy;
		force_out.fz <= s2_fz;
	end

	// Several pairs may be in flight
	always_ff @(posedge clk)
	begin
		if (rst)
			vld <= '0;
		else
			vld <= {vld[LAT-2:0], issue_valid};
	end

	assign force_valid = vld[LAT-1];

endmodule

/* pair_filter.sv */
/*
  Three-stage difference, square and cutoff filter with its buffer.
  Kept pairs are r2 strictly below the cutoff. back_pressure leaves room for
  every pair between the input FIFO read and the buffer write.
*/
`timescale 1ns/100ps
`include "md_cfg.svh"

module pair_filter
(
	input  logic                     clk,
	input  logic                     rst,
	// From the input FIFO, one cycle after its read
	input  logic                     in_valid,
	input  md_pair_pkg::pair_in_t    in_pair,
	input  logic [`MD_R2_W-1:0]      cutoff,
	// Buffer read side
	input  logic                     pop,
	output md_force_pkg::kept_pair_t kept,
	output logic                     kept_available,
	output logic                     back_pressure
);

	localparam int LAT = `MD_FILT_LATENCY;
	localparam int CNT_W = $clog2(`MD_FILT_DEPTH + 1);
	// Stall while free space is LAT + 1 or less
	localparam logic [CNT_W-1:0] BP_LEVEL = CNT_W'(`MD_FILT_DEPTH - LAT - 1);

	// Valid bits shifted along the stages
	logic [LAT-1:0] vld;

	// Stage registers
	md_pair_pkg::pair_ids_t   s1_ids;
	md_pair_pkg::diff_t       s1_diff;
	md_pair_pkg::pair_ids_t   s2_ids;
	md_pair_pkg::diff_t       s2_diff;
	logic [`MD_R2_W-1:0]      s2_sq_x;
	logic [`MD_R2_W-1:0]      s2_sq_y;
	logic [`MD_R2_W-1:0]      s2_sq_z;
	md_force_pkg::kept_pair_t s3_pair;
	logic                     s3_keep;

	logic [`MD_R2_W-1:0] r2_sum;
	logic [CNT_W-1:0]    buf_used;
	logic                buf_empty;
	logic                buf_wr;

	////////////////////////////////////////////////////////////
	// Arithmetic stages
	////////////////////////////////////////////////////////////
	// Sum of squares feeding the compare
	assign r2_sum = s2_sq_x + s2_sq_y + s2_sq_z;

	always_ff @(posedge clk)
	begin
		// Stage 1 neighbor minus reference, zero extended to signed
		s1_ids <= in_pair.ids;
		s1_diff.dx <= $signed({1'b0, in_pair.nbr_pos.x}) - $signed({1'b0, in_pair.ref_pos.x});
		s1_diff.dy <= $signed({1'b0, in_pair.nbr_pos.y}) - $signed({1'b0, in_pair.ref_pos.y});
		s1_diff.dz <= $signed({1'b0, in_pair.nbr_pos.z}) - $signed({1'b0, in_pair.ref_pos.z});
		// Stage 2 squares, always non-negative
		s2_ids <= s1_ids;
		s2_diff <= s1_diff;
		s2_sq_x <= s1_diff.dx * s1_diff.dx;
		s2_sq_y <= s1_diff.dy * s1_diff.dy;
		s2_sq_z <= s1_diff.dz * s1_diff.dz;
		// Stage 3 r2 and cutoff decision
		s3_pair.ids <= s2_ids;
		s3_pair.diff <= s2_diff;
		s3_pair.r2.raw <= r2_sum;
		s3_keep <= (r2_sum < cutoff);
	end

	// Valid follows the data one stage per cycle
	always_ff @(posedge clk)
	begin
		if (rst)
			vld <= '0;
		else
			vld <= {vld[LAT-2:0], in_valid};
	end

	////////////////////////////////////////////////////////////
	// Filter buffer
	////////////////////////////////////////////////////////////
	assign buf_wr = vld[LAT-1] && s3_keep;
	assign kept_available = ~buf_empty;
	// Used count covers in-flight pairs with margin
	assign back_pressure = (buf_used >= BP_LEVEL);

	pair_fifo
	#(
		.WIDTH($bits(md_force_pkg::kept_pair_t)),
		.DEPTH(`MD_FILT_DEPTH)
	)
	u_filt_buf
	(
		.clk(clk),
		.rst(rst),
		.wr_en(buf_wr),
		.wr_data(s3_pair),
		.rd_en(pop),
		.rd_data(kept),
		.empty(buf_empty),
		.used(buf_used)
	);

endmodule

/* cutoff_regs.sv */
/*
  Squared cutoff register. A load on cfg_we is seen from the next cycle on.
*/
`timescale 1ns/100ps
`include "md_cfg.svh"

module cutoff_regs
(
	input  logic                clk,
	input  logic                rst,
	// Configuration strobe and value
	input  logic                cfg_we,
	input  logic [`MD_R2_W-1:0] cfg_cutoff,
	// To the filter compare stage
	output logic [`MD_R2_W-1:0] cutoff
);

	////////////////////////////////////////////////////////////
	// Cutoff register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cutoff <= `MD_CUTOFF_RESET;
		end
		else if (cfg_we)
		begin
			// Takes effect on the next edge
			cutoff <= cfg_cutoff;
		end
	end

endmodule

/* pair_fifo.sv */
/*
  Synchronous FIFO. DEPTH must be a power of two.
  rd_data updates one cycle after rd_en. Overflow and underflow are not guarded.
*/
`timescale 1ns/100ps

module pair_fifo
#(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16,
	localparam int PTR_W = $clog2(DEPTH),
	localparam int CNT_W = $clog2(DEPTH + 1)
)
(
	input  logic             clk,
	input  logic             rst,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] wr_data,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic             empty,
	output logic [CNT_W-1:0] used
);

	// Storage array
	logic [WIDTH-1:0] mem [0:DEPTH-1];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	assign empty = (used == '0);

	////////////////////////////////////////////////////////////
	// Data path
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
		// Read data held until the next read
		if (rd_en)
			rd_data <= mem[rd_ptr];
	end

	////////////////////////////////////////////////////////////
	// Pointers and word count
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used <= '0;
		end
		else
		begin
			// Pointers wrap on their own width
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous read and write leaves count alone
			case ({wr_en, rd_en})
				2'b10: used <= used + 1'b1;
				2'b01: used <= used - 1'b1;
				default: used <= used;
			endcase
		end
	end

endmodule

/* md_force_pkg.sv */
/*
  Types for kept pairs and force results.
  The r2 word is read raw for the cutoff and as bin plus fraction for the table.
*/
`include "md_cfg.svh"

package md_force_pkg;

	// Table view of r2, with the upper bits as the bin
	typedef struct packed
	{
		logic [`MD_BIN_W-1:0]          bin;
		logic [`MD_R2_W-`MD_BIN_W-1:0] frac;
	} r2_fields_t;

	// Same r2 word decoded two ways
	typedef union packed
	{
		logic [`MD_R2_W-1:0] raw;
		r2_fields_t          fields;
	} r2_word_u;

	// Filter buffer word and pipeline input
	typedef struct packed
	{
		md_pair_pkg::pair_ids_t ids;
		md_pair_pkg::diff_t     diff;
		r2_word_u               r2;
	} kept_pair_t;

	// Output FIFO word and output port
	typedef struct packed
	{
		md_pair_pkg::pair_ids_t        ids;
		logic signed [`MD_FORCE_W-1:0] fx;
		logic signed [`MD_FORCE_W-1:0] fy;
		logic signed [`MD_FORCE_W-1:0] fz;
	} force_out_t;

endpackage

/* md_pair_pkg.sv */
/*
  Types for a particle pair at the input port and inside the filter.
  Coordinates are unsigned. Differences are neighbor minus reference.
*/
`include "md_cfg.svh"

package md_pair_pkg;

	// Particle IDs of one pair
	typedef struct packed
	{
		logic [`MD_ID_W-1:0] ref_id;
		logic [`MD_ID_W-1:0] nbr_id;
	} pair_ids_t;

	// One particle position, unsigned per axis
	typedef struct packed
	{
		logic [`MD_COORD_W-1:0] x;
		logic [`MD_COORD_W-1:0] y;
		logic [`MD_COORD_W-1:0] z;
	} position_t;

	// Input port word and input FIFO word
	typedef struct packed
	{
		pair_ids_t ids;
		position_t ref_pos;
		position_t nbr_pos;
	} pair_in_t;

	// Signed per-axis differences
	// Range is +/- (2**MD_COORD_W - 1)
	typedef struct packed
	{
		logic signed [`MD_DIFF_W-1:0] dx;
		logic signed [`MD_DIFF_W-1:0] dy;
		logic signed [`MD_DIFF_W-1:0] dz;
	} diff_t;

endpackage

/* md_cfg.svh */
/*
  Build-time sizes for the pair filter and force evaluator.
  FIFO depths must be powers of two. Both stage counts are fixed at 3 by the RTL.
  MD_R2_W must hold the sum of three squared MD_DIFF_W differences.
*/
`ifndef MD_CFG_SVH
`define MD_CFG_SVH

// Particle data widths
`define MD_COORD_W        10
`define MD_ID_W           21
`define MD_DIFF_W         11
`define MD_R2_W           22

// Table lookup and force widths
`define MD_BIN_W          8
`define MD_COEF_W         8
`define MD_FORCE_W        20

// Buffer depths
`define MD_IN_DEPTH       4
`define MD_FILT_DEPTH     16
`define MD_OUT_DEPTH      16

// Pipeline stage counts
`define MD_FILT_LATENCY   3
`define MD_FORCE_LATENCY  3

// Squared cutoff loaded by reset
`define MD_CUTOFF_RESET   22'h100000

`endif
